// ==== rtl/lpc_pkg.sv ====
// lpc analysis front end shared definitions
// frame constants, sign-magnitude fixed-point types and arithmetic
package lpc_pkg;

	// ----------------------------------------
	// frame and word constants
	// ----------------------------------------
	localparam int FRAME_LEN = 320;
	localparam int ORDER = 10;
	localparam int NUM_LAGS = ORDER + 1;
	localparam int FRAC_BITS = 16;
	localparam int WORD_W = 32;
	localparam int ACC_W = 48;
	localparam int IDX_W = 9;

	// write pipeline depth and accumulate pipeline depth
	localparam int DRAIN_CYCLES = 2;
	localparam int FLUSH_CYCLES = 3;

	// ----------------------------------------
	// types
	// ----------------------------------------
	// 1 sign, 15 integer, 16 fraction bits
	typedef struct packed {
		logic sign;
		logic [WORD_W-2:0] mag;
	} fix_fields_t;

	// stored as raw word, decoded as sign/magnitude for math
	typedef union packed {
		logic [WORD_W-1:0] raw;
		fix_fields_t fld;
	} fix_word_u;

	// autocorrelation sum
	typedef struct packed {
		logic sign;
		logic [ACC_W-2:0] mag;
	} acc_t;

	typedef struct packed {
		fix_word_u sample;
		fix_word_u weight;
	} sample_in_t;

	typedef struct packed {
		logic [IDX_W-1:0] n;
		logic [IDX_W-1:0] lag;
	} frame_idx_t;

	typedef struct packed {
		logic clear;
		logic load_en;
		logic corr_en;
		logic step_n;
		logic step_lag;
	} seq_ctl_t;

	// ----------------------------------------
	// sign-magnitude arithmetic
	// ----------------------------------------
	function automatic fix_word_u fix_mult(input fix_word_u a, input fix_word_u b);
		logic [2*WORD_W-3:0] prod;
		fix_word_u res;
		prod = a.fld.mag * b.fld.mag;
		res.fld.sign = a.fld.sign ^ b.fld.sign;
		// drop fraction bits, keep low 31 of the rest
		res.fld.mag = prod[FRAC_BITS +: WORD_W-1];
		return res;
	endfunction

	function automatic fix_word_u fix_add(input fix_word_u a, input fix_word_u b);
		fix_word_u res;
		if (a.fld.sign == b.fld.sign)
		begin
			res.fld.mag = a.fld.mag + b.fld.mag;
			res.fld.sign = a.fld.sign;
		end
		else if (a.fld.mag >= b.fld.mag)
		begin
			res.fld.mag = a.fld.mag - b.fld.mag;
			res.fld.sign = a.fld.sign;
		end
		else
		begin
			res.fld.mag = b.fld.mag - a.fld.mag;
			res.fld.sign = b.fld.sign;
		end
		// no negative zero
		if (res.fld.mag == '0)
			res.fld.sign = 1'b0;
		return res;
	endfunction

	function automatic acc_t acc_add(input acc_t a, input acc_t b);
		acc_t res;
		if (a.sign == b.sign)
		begin
			res.mag = a.mag + b.mag;
			res.sign = a.sign;
		end
		else if (a.mag >= b.mag)
		begin
			res.mag = a.mag - b.mag;
			res.sign = a.sign;
		end
		else
		begin
			res.mag = b.mag - a.mag;
			res.sign = b.sign;
		end
		if (res.mag == '0)
			res.sign = 1'b0;
		return res;
	endfunction

	// zero bits go above the magnitude, sign carried over
	function automatic acc_t widen(input fix_word_u w);
		acc_t res;
		res.sign = w.fld.sign;
		res.mag = {{(ACC_W-WORD_W){1'b0}}, w.fld.mag};
		return res;
	endfunction

endpackage

// ==== rtl/lag_counter.sv ====
// sample index and lag counters
// flags the last sample of a lag and the last lag
`timescale 1ns/1ps

module lag_counter
(
	input logic clk,
	input logic rst,
	input lpc_pkg::seq_ctl_t ctl,
	output lpc_pkg::frame_idx_t idx,
	output logic last_n,
	output logic last_lag
);

	logic [lpc_pkg::IDX_W-1:0] n;
	logic [lpc_pkg::IDX_W-1:0] lag;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			n <= '0;
			lag <= '0;
		end
		else if (ctl.clear)
		begin
			n <= '0;
			lag <= '0;
		end
		else if (ctl.step_lag)
		begin
			// next lag starts at sample zero
			n <= '0;
			lag <= lag + 1'b1;
		end
		else if (ctl.step_n)
		begin
			// wrap after the last load strobe, ready for correlation
			if (last_n)
				n <= '0;
			else
				n <= n + 1'b1;
		end
	end

	// ----------------------------------------
	// range flags
	// ----------------------------------------
	// lag is zero while loading, so this is also end of frame
	assign last_n = (n == lpc_pkg::IDX_W'(lpc_pkg::FRAME_LEN - 1) - lag);
	assign last_lag = (lag == lpc_pkg::IDX_W'(lpc_pkg::ORDER));

	assign idx.n = n;
	assign idx.lag = lag;

endmodule

// ==== rtl/analysis_sequencer.sv ====
// analysis sequencer
// steps the frame through clear, load, drain, correlate, flush and done
`timescale 1ns/1ps

module analysis_sequencer
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic sample_valid,
	input logic last_n,
	input logic last_lag,
	output lpc_pkg::seq_ctl_t ctl,
	output logic done
);

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_CLEAR,
		S_LOAD,
		S_DRAIN,
		S_CORR,
		S_FLUSH,
		S_DONE
	} state_t;

	state_t state;
	state_t next_state;
	// counts down the drain and flush cycles
	logic [1:0] wait_cnt;

	// ----------------------------------------
	// state register
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			wait_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == S_LOAD && next_state == S_DRAIN)
				wait_cnt <= 2'(lpc_pkg::DRAIN_CYCLES - 1);
			else if (state == S_CORR && next_state == S_FLUSH)
				wait_cnt <= 2'(lpc_pkg::FLUSH_CYCLES - 1);
			else if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 2'd1;
		end
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE, S_DONE:
				if (start)
					next_state = S_CLEAR;
			S_CLEAR:
				next_state = S_LOAD;
			S_LOAD:
				// last strobe of the frame
				if (sample_valid && last_n)
					next_state = S_DRAIN;
			S_DRAIN:
				if (wait_cnt == '0)
					next_state = S_CORR;
			S_CORR:
				if (last_n && last_lag)
					next_state = S_FLUSH;
			S_FLUSH:
				if (wait_cnt == '0)
					next_state = S_DONE;
			default:
				next_state = S_IDLE;
		endcase
	end

	// ----------------------------------------
	// controls
	// ----------------------------------------
	always_comb
	begin
		ctl.clear = (state == S_CLEAR);
		ctl.load_en = (state == S_LOAD);
		ctl.corr_en = (state == S_CORR);
		// load steps on strobes, correlation steps every cycle
		ctl.step_n = (state == S_LOAD && sample_valid) || (state == S_CORR);
		ctl.step_lag = (state == S_CORR) && last_n;
	end

	assign done = (state == S_DONE);

endmodule

// ==== rtl/window_store.sv ====
// windowing and sample store
// windows each sample, sums the frame energy, serves sample pairs
`timescale 1ns/1ps

module window_store
(
	input logic clk,
	input logic rst,
	input logic sample_valid,
	input lpc_pkg::sample_in_t sample_in,
	input lpc_pkg::seq_ctl_t ctl,
	input lpc_pkg::frame_idx_t idx,
	output lpc_pkg::fix_word_u energy,
	output lpc_pkg::fix_word_u a_word,
	output lpc_pkg::fix_word_u b_word,
	output logic pair_valid
);

	logic [lpc_pkg::WORD_W-1:0] mem [lpc_pkg::FRAME_LEN];

	// stage 1 windowed product with its index
	logic w_valid;
	lpc_pkg::fix_word_u w_word;
	logic [lpc_pkg::IDX_W-1:0] w_idx;
	logic [lpc_pkg::IDX_W-1:0] b_addr;

	// ----------------------------------------
	// write pipeline
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			w_valid <= 1'b0;
		else
			w_valid <= sample_valid && ctl.load_en;
	end

	always_ff @(posedge clk)
	begin
		if (sample_valid && ctl.load_en)
		begin
			w_word <= lpc_pkg::fix_mult(sample_in.sample, sample_in.weight);
			w_idx <= idx.n;
		end
		if (w_valid)
			mem[w_idx] <= w_word.raw;
	end

	// energy sums squares of windowed samples
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			energy.raw <= '0;
		else if (ctl.clear)
			energy.raw <= '0;
		else if (w_valid)
			energy <= lpc_pkg::fix_add(energy, lpc_pkg::fix_mult(w_word, w_word));
	end

	// ----------------------------------------
	// pair read on two ports
	// ----------------------------------------
	assign b_addr = idx.n + idx.lag;

	always_ff @(posedge clk)
	begin
		if (ctl.corr_en)
		begin
			a_word.raw <= mem[idx.n];
			b_word.raw <= mem[b_addr];
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			pair_valid <= 1'b0;
		else
			pair_valid <= ctl.corr_en;
	end

endmodule

// ==== rtl/autocorr_accum.sv ====
// autocorrelation accumulators
// multiplies each sample pair and sums it into the bank for its lag
`timescale 1ns/1ps

module autocorr_accum
(
	input logic clk,
	input logic rst,
	input lpc_pkg::seq_ctl_t ctl,
	input lpc_pkg::frame_idx_t idx,
	input lpc_pkg::fix_word_u a_word,
	input lpc_pkg::fix_word_u b_word,
	input logic pair_valid,
	output lpc_pkg::acc_t r [lpc_pkg::NUM_LAGS]
);

	// lag tag follows its pair down the pipe
	logic [lpc_pkg::IDX_W-1:0] lag_d1;
	logic [lpc_pkg::IDX_W-1:0] lag_d2;
	logic valid_d2;
	lpc_pkg::fix_word_u prod;

	// ----------------------------------------
	// stage 1 tag lines up with the read
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		lag_d1 <= idx.lag;
	end

	// ----------------------------------------
	// stage 2 multiply
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			valid_d2 <= 1'b0;
		else
			valid_d2 <= pair_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pair_valid)
		begin
			prod <= lpc_pkg::fix_mult(a_word, b_word);
			lag_d2 <= lag_d1;
		end
	end

	// ----------------------------------------
	// stage 3 accumulate into selected lag
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < lpc_pkg::NUM_LAGS; i++)
				r[i] <= '0;
		end
		else if (ctl.clear)
		begin
			for (int i = 0; i < lpc_pkg::NUM_LAGS; i++)
				r[i] <= '0;
		end
		else if (valid_d2)
		begin
			// one bank entry updates per cycle
			for (int i = 0; i < lpc_pkg::NUM_LAGS; i++)
			begin
				if (lag_d2 == lpc_pkg::IDX_W'(i))
					r[i] <= lpc_pkg::acc_add(r[i], lpc_pkg::widen(prod));
			end
		end
	end

endmodule

// ==== rtl/lpc_autocorr_top.sv ====
// lpc autocorrelation front end
// windowed energy and autocorrelation for lags 0 to 10 over one frame
`timescale 1ns/1ps

module lpc_autocorr_top
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic sample_valid,
	input lpc_pkg::sample_in_t sample_in,
	output lpc_pkg::fix_word_u energy,
	output lpc_pkg::acc_t r [lpc_pkg::NUM_LAGS],
	output logic done
);

	lpc_pkg::seq_ctl_t ctl;
	lpc_pkg::frame_idx_t idx;
	logic last_n;
	logic last_lag;
	// pair from the store to the accumulators
	lpc_pkg::fix_word_u a_word;
	lpc_pkg::fix_word_u b_word;
	logic pair_valid;

	// ----------------------------------------
	// control
	// ----------------------------------------
	analysis_sequencer u_seq
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.sample_valid(sample_valid),
		.last_n(last_n),
		.last_lag(last_lag),
		.ctl(ctl),
		.done(done)
	);

	lag_counter u_cnt
	(
		.clk(clk),
		.rst(rst),
		.ctl(ctl),
		.idx(idx),
		.last_n(last_n),
		.last_lag(last_lag)
	);

	// ----------------------------------------
	// data path
	// ----------------------------------------
	window_store u_store
	(
		.clk(clk),
		.rst(rst),
		.sample_valid(sample_valid),
		.sample_in(sample_in),
		.ctl(ctl),
		.idx(idx),
		.energy(energy),
		.a_word(a_word),
		.b_word(b_word),
		.pair_valid(pair_valid)
	);

	autocorr_accum u_acc
	(
		.clk(clk),
		.rst(rst),
		.ctl(ctl),
		.idx(idx),
		.a_word(a_word),
		.b_word(b_word),
		.pair_valid(pair_valid),
		.r(r)
	);

endmodule

// ==== verif/tb_lpc_autocorr.sv ====
// testbench for the lpc autocorrelation front end
// random frames checked against a sign-magnitude reference model
`timescale 1ns/1ps

module tb_lpc_autocorr;

	localparam int N_FRAMES = 4;
	// pairs issued over all eleven lags
	localparam int PAIR_COUNT = lpc_pkg::NUM_LAGS * lpc_pkg::FRAME_LEN
		- lpc_pkg::ORDER * (lpc_pkg::ORDER + 1) / 2;
	localparam longint FRAME_CYCLES = 2 * lpc_pkg::FRAME_LEN + PAIR_COUNT + 50;
	localparam longint TIMEOUT_NS = N_FRAMES * FRAME_CYCLES * 20 * 2;

	logic clk;
	logic rst;
	logic start;
	logic sample_valid;
	lpc_pkg::sample_in_t sample_in;
	lpc_pkg::fix_word_u energy;
	lpc_pkg::acc_t r [lpc_pkg::NUM_LAGS];
	logic done;

	logic [15:0] lfsr;
	// current frame as raw sign-magnitude words
	logic [31:0] samp [lpc_pkg::FRAME_LEN];
	logic [31:0] wt [lpc_pkg::FRAME_LEN];
	logic [31:0] win [lpc_pkg::FRAME_LEN];
	// expected results of the frame in flight
	logic [31:0] exp_energy;
	logic [47:0] exp_r [lpc_pkg::NUM_LAGS];
	int frames_checked = 0;

	lpc_autocorr_top uut
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.sample_valid(sample_valid),
		.sample_in(sample_in),
		.energy(energy),
		.r(r),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// random bits and reference arithmetic
	// ----------------------------------------
	function automatic logic [31:0] lfsr_bits(input int width);
		logic fb;
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < width; i++)
		begin
			// taps 16, 14, 13, 11
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] sm_mul(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] p;
		p = {33'd0, a[30:0]} * {33'd0, b[30:0]};
		// back to 16 fraction bits
		return {a[31] ^ b[31], p[46:16]};
	endfunction

	function automatic logic [47:0] sm_add(input logic [47:0] a, input logic [47:0] b);
		logic [46:0] m;
		logic s;
		if (a[47] == b[47])
		begin
			m = a[46:0] + b[46:0];
			s = a[47];
		end
		else if (a[46:0] >= b[46:0])
		begin
			m = a[46:0] - b[46:0];
			s = a[47];
		end
		else
		begin
			m = b[46:0] - a[46:0];
			s = b[47];
		end
		// zero is always positive
		if (m == '0)
			s = 1'b0;
		return {s, m};
	endfunction

	function automatic logic [47:0] to_acc(input logic [31:0] w);
		return {w[31], 16'd0, w[30:0]};
	endfunction

	function automatic void ref_model();
		logic [47:0] e;
		e = '0;
		for (int i = 0; i < lpc_pkg::FRAME_LEN; i++)
		begin
			win[i] = sm_mul(samp[i], wt[i]);
			e = sm_add(e, to_acc(sm_mul(win[i], win[i])));
		end
		// energy stays well below 2^31, narrowing is exact
		exp_energy = {e[47], e[30:0]};
		for (int k = 0; k < lpc_pkg::NUM_LAGS; k++)
		begin
			exp_r[k] = '0;
			for (int i = 0; i + k < lpc_pkg::FRAME_LEN; i++)
				exp_r[k] = sm_add(exp_r[k], to_acc(sm_mul(win[i], win[i + k])));
		end
	endfunction

	task automatic check(input string name, input logic [47:0] expected,
		input logic [47:0] actual);
		if (actual !== expected)
		begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
			$display("Something failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic gen_frame(input bit zero_weights);
		logic [31:0] s_bits;
		logic [31:0] w_bits;
		for (int i = 0; i < lpc_pkg::FRAME_LEN; i++)
		begin
			// sign then 18 magnitude bits
			s_bits = lfsr_bits(19);
			samp[i] = {s_bits[18], 13'd0, s_bits[17:0]};
			// positive weight below one
			w_bits = lfsr_bits(16);
			wt[i] = zero_weights ? 32'd0 : {16'd0, w_bits[15:0]};
		end
	endtask

	// pulses start and returns once the sequencer sits in load
	task automatic pulse_start();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		@(negedge clk);
	endtask

	task automatic load_frame(input bit gaps);
		logic [31:0] g;
		for (int i = 0; i < lpc_pkg::FRAME_LEN; i++)
		begin
			sample_valid = 1'b1;
			sample_in.sample.raw = samp[i];
			sample_in.weight.raw = wt[i];
			@(negedge clk);
			sample_valid = 1'b0;
			if (gaps)
			begin
				g = lfsr_bits(1);
				if (g[0])
					@(negedge clk);
			end
		end
	endtask

	// junk starts and strobes while the frame drains and correlates
	task automatic disturb();
		logic [31:0] bits;
		for (int i = 0; i < 24; i++)
		begin
			bits = lfsr_bits(2);
			start = bits[0];
			sample_valid = bits[1];
			sample_in.sample.raw = lfsr_bits(32);
			sample_in.weight.raw = lfsr_bits(16);
			@(negedge clk);
		end
		start = 1'b0;
		sample_valid = 1'b0;
	endtask

	initial
	begin
		lfsr = 16'd47360;
		rst = 1'b1;
		start = 1'b0;
		sample_valid = 1'b0;
		sample_in = '0;
		@(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		// idle outputs after reset
		check("done", 48'd0, {47'd0, done});
		check("energy", 48'd0, {16'd0, energy.raw});
		for (int k = 0; k < lpc_pkg::NUM_LAGS; k++)
			check($sformatf("r[%0d]", k), 48'd0, r[k]);
		// frame 1 back to back, 2 with gaps, 3 zero weights, 4 disturbed
		for (int f = 0; f < N_FRAMES; f++)
		begin
			gen_frame(f == 2);
			ref_model();
			pulse_start();
			load_frame(f == 1);
			if (f == 3)
				disturb();
			wait (frames_checked == f + 1);
			@(negedge clk);
		end
		$display("Everything OK");
		$finish;
	end

	// ----------------------------------------
	// compare and watchdog
	// ----------------------------------------
	initial
	begin
		forever
		begin
			@(posedge done);
			@(negedge clk);
			check("energy", {16'd0, exp_energy}, {16'd0, energy.raw});
			// lag 0 equals the widened energy
			check("r[0] vs energy", to_acc(exp_energy), r[0]);
			for (int k = 0; k < lpc_pkg::NUM_LAGS; k++)
				check($sformatf("r[%0d]", k), exp_r[k], r[k]);
			frames_checked = frames_checked + 1;
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the frames did not finish within %0d ns", TIMEOUT_NS);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== verilog.f ====
rtl/lpc_pkg.sv
rtl/lag_counter.sv
rtl/analysis_sequencer.sv
rtl/window_store.sv
rtl/autocorr_accum.sv
rtl/lpc_autocorr_top.sv
verif/tb_lpc_autocorr.sv

// ==== Makefile ====
# Verilator build for the LPC autocorrelation front end
VERILATOR ?= verilator
TOP ?= tb_lpc_autocorr
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Everything OK
VFLAGS ?= --timing

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
